// File: common/dense_layer_defs.svh
`ifndef DENSE_LAYER_DEFS_SVH
`define DENSE_LAYER_DEFS_SVH

// words per input vector, one per accepted transfer
`define DL_N_INPUTS 8

// neurons in the layer, one MAC lane and one output word each
`define DL_N_LANES 4

// width of every data word, inputs through results
`define DL_WORD_W 16

`endif

// File: common/dense_layer_pkg.sv
`default_nettype none

`include "dense_layer_defs.svh"

package dense_layer_pkg;

   typedef logic signed [`DL_WORD_W-1:0] word_t;

   // index of a word inside the input vector
   typedef logic [$clog2(`DL_N_INPUTS)-1:0] in_addr_t;

   // index of a result inside the output burst
   typedef logic [$clog2(`DL_N_LANES)-1:0] lane_sel_t;

   typedef word_t [`DL_N_LANES-1:0] lane_words_t;

   typedef enum logic [1:0] {
      idle,
      load,
      compute,
      wait_out
   } ctrl_state_t;

   typedef struct packed {
      logic clear;
      logic acc;
      logic capture;
   } mac_ctrl_t;

   // row j holds the weights of neuron j, column i multiplies input word i
   localparam word_t weight_table [`DL_N_LANES][`DL_N_INPUTS] = '{
      '{ -10,  102,   27,   43,  -56,  -16,    6,  114},
      '{ -81,  -49,  -50,  126, -120,  -55,   70,  -10},
      '{ -96,   81,  -82, -109,   55,  119,   88,  -90},
      '{  51,   51,  126,   27,   87,  -21,  -32,  -50}
   };

   localparam word_t bias_table [`DL_N_LANES] = '{-109, 91, -43, 99};

endpackage

`default_nettype wire

// File: dense_layer.f
+incdir+common
common/dense_layer_pkg.sv
source/layer_ctrl.sv
source/input_buffer.sv
mac_array/weight_rom.sv
mac_array/mac_lane.sv
source/output_serializer.sv
source/dense_layer_top.sv
sim/tb_clock.sv
sim/dense_layer_checker.sv
sim/dense_layer_tb.sv

// File: mac_array/mac_lane.sv
`default_nettype none

module mac_lane #(
   parameter int lane_index = 0
) (
   input  logic                       clk,
   input  logic                       reset,
   input  dense_layer_pkg::mac_ctrl_t mac_ctrl,
   input  dense_layer_pkg::word_t     x,
   input  dense_layer_pkg::word_t     weight,
   input  dense_layer_pkg::word_t     bias,
   output dense_layer_pkg::word_t     result
);
   import dense_layer_pkg::*;

   word_t product;
   word_t acc_q;

   // 16 bit context, so the product wraps like the sum
   assign product = x * weight;

   // clear wins over acc on the first product of a vector
   always_ff @(posedge clk) begin
      if (mac_ctrl.clear) begin
         acc_q <= bias + product;
      end else if (mac_ctrl.acc) begin
         acc_q <= acc_q + product;
      end
   end

   // relu, zero and negative sums both give zero
   always_ff @(posedge clk) begin
      if (reset) begin
         result <= '0;
      end else if (mac_ctrl.capture) begin
         result <= (acc_q > 0) ? acc_q : '0;
      end
   end

   // lane slice at the top must match this lane's row of the table
   a_bias_matches_lane: assert property (
      @(posedge clk) disable iff (reset)
      mac_ctrl.clear |-> bias == bias_table[lane_index]
   );

endmodule

`default_nettype wire

// File: mac_array/weight_rom.sv
`default_nettype none

`include "dense_layer_defs.svh"

module weight_rom (
   input  logic                         clk,
   input  dense_layer_pkg::in_addr_t    addr,
   output dense_layer_pkg::lane_words_t weights,
   output dense_layer_pkg::lane_words_t biases
);
   import dense_layer_pkg::*;

   // one column of the matrix per cycle, every lane gets its own row entry
   always_ff @(posedge clk) begin
      for (int j = 0; j < `DL_N_LANES; j++) begin
         weights[j] <= weight_table[j][addr];
         biases[j]  <= bias_table[j];
      end
   end

endmodule

`default_nettype wire

// File: sim/dense_layer_checker.sv
`default_nettype none

module dense_layer_checker (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   s_ready,
   input  logic                   m_valid,
   input  logic                   m_ready,
   input  dense_layer_pkg::word_t m_data,
   output int                     error_count,
   output int                     checked_count,
   output int                     pending
);
   timeunit 1ns;
   timeprecision 100ps;

   import dense_layer_pkg::*;

   word_t expected_q [$];
   int    reset_edges;
   int    edges_after_reset;
   logic  stalled;
   word_t stalled_data;

   initial begin
      error_count       = 0;
      checked_count     = 0;
      pending           = 0;
      reset_edges       = 0;
      edges_after_reset = 0;
      stalled           = 1'b0;
      stalled_data      = '0;
   end

   // called by the stimulus for every word it expects, in vector and lane order
   function automatic void push_expected(input word_t w);
      expected_q.push_back(w);
      pending = expected_q.size();
   endfunction

   function automatic void report_value(input string name, input logic [15:0] got,
                                        input logic [15:0] want, input string where);
      $display("error: %s = 0x%h, expected 0x%h, %s", name, got, want, where);
      error_count++;
   endfunction

   // sampled on the rising edge, before the DUT registers update
   always @(posedge clk) begin
      word_t want;
      if (reset) begin
         edges_after_reset = 0;
         stalled           = 1'b0;
         // the first edge is the one that resets the DUT
         if (reset_edges > 0) begin
            if (s_ready !== 1'b0) report_value("s_ready", s_ready, 16'h0, "during reset");
            if (m_valid !== 1'b0) report_value("m_valid", m_valid, 16'h0, "during reset");
         end
         reset_edges++;
      end else begin
         if (edges_after_reset == 0) begin
            if (s_ready !== 1'b0) report_value("s_ready", s_ready, 16'h0, "as reset falls");
            if (m_valid !== 1'b0) report_value("m_valid", m_valid, 16'h0, "as reset falls");
         end else if (edges_after_reset == 1 && s_ready !== 1'b1) begin
            report_value("s_ready", s_ready, 16'h1, "one cycle after reset");
         end
         if (edges_after_reset < 2) edges_after_reset++;

         if (stalled) begin
            if (m_valid !== 1'b1) begin
               $display("m_valid dropped while the output was stalled by m_ready");
               error_count++;
            end else if (m_data !== stalled_data) begin
               report_value("m_data", m_data, stalled_data, "changed while stalled");
            end
         end

         if (m_valid === 1'b1 && m_ready === 1'b1) begin
            if (expected_q.size() == 0) begin
               $display("output word 0x%h arrived with no vector outstanding", m_data);
               error_count++;
            end else begin
               want = expected_q.pop_front();
               pending = expected_q.size();
               checked_count++;
               if (m_data !== want) begin
                  report_value("m_data", m_data, want, $sformatf("output %0d", checked_count));
               end
            end
         end

         stalled      = m_valid && !m_ready;
         stalled_data = m_data;
      end
   end

endmodule

`default_nettype wire

// File: sim/dense_layer_tb.sv
`default_nettype none

`include "dense_layer_defs.svh"

module dense_layer_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import dense_layer_pkg::*;

   localparam logic [31:0] lfsr_seed     = 32'h07ee_b3b1;
   localparam int          ready_timeout = 1000;
   localparam int          drain_timeout = 4000;

   logic  clk;
   logic  reset;
   logic  s_valid;
   logic  s_ready;
   logic  m_valid;
   logic  m_ready;
   word_t s_data;
   word_t m_data;
   int    error_count;
   int    checked_count;
   int    pending;

   logic [31:0] stim_lfsr  = lfsr_seed;
   logic [31:0] ready_lfsr = lfsr_seed;
   // 0 keeps m_ready high, 1 is a fair coin, 2 is ready one cycle in four
   int          ready_mode = 0;
   word_t       vec [`DL_N_INPUTS];
   int          tests_run;
   int          tests_failed;
   int          errors_before;
   int          checked_before;

   tb_clock i_tb_clock (.clk(clk));

   dense_layer_top i_dense_layer_top (
      .clk     (clk),
      .reset   (reset),
      .s_valid (s_valid),
      .s_data  (s_data),
      .s_ready (s_ready),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_data  (m_data)
   );

   dense_layer_checker i_dense_layer_checker (
      .clk           (clk),
      .reset         (reset),
      .s_ready       (s_ready),
      .m_valid       (m_valid),
      .m_ready       (m_ready),
      .m_data        (m_data),
      .error_count   (error_count),
      .checked_count (checked_count),
      .pending       (pending)
   );

   // right shift Galois form, taps 32 31 29 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) return (state >> 1) ^ 32'hD000_0001;
      return state >> 1;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r = {r[30:0], stim_lfsr[0]};
         stim_lfsr = lfsr_step(stim_lfsr);
      end
      return r;
   endfunction

   // bias plus the dot product, every step wrapped to 16 bits, then relu
   function automatic lane_words_t relu_layer_ref(input word_t x [`DL_N_INPUTS]);
      lane_words_t y;
      word_t       sum;
      word_t       prod;
      for (int j = 0; j < `DL_N_LANES; j++) begin
         sum = bias_table[j];
         for (int i = 0; i < `DL_N_INPUTS; i++) begin
            prod = x[i] * weight_table[j][i];
            sum  = sum + prod;
         end
         y[j] = (sum > 0) ? sum : word_t'(0);
      end
      return y;
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TEST RESULT: FAIL");
      $finish;
   endtask

   task automatic random_vector();
      for (int i = 0; i < `DL_N_INPUTS; i++) vec[i] = word_t'(random_bits(16));
   endtask

   // entered and left on a falling edge
   task automatic send_vector(input int max_gap);
      lane_words_t expected;
      int          gap;
      int          waited;
      expected = relu_layer_ref(vec);
      for (int j = 0; j < `DL_N_LANES; j++) i_dense_layer_checker.push_expected(expected[j]);
      for (int i = 0; i < `DL_N_INPUTS; i++) begin
         gap = (max_gap > 0) ? int'(random_bits(2)) % (max_gap + 1) : 0;
         repeat (gap) begin
            s_valid = 1'b0;
            @(negedge clk);
         end
         s_valid = 1'b1;
         s_data  = vec[i];
         waited  = 0;
         while (!s_ready) begin
            @(negedge clk);
            waited++;
            if (waited > ready_timeout) abort_run("input word was never accepted, s_ready stuck low");
         end
         // s_ready was high before this rising edge, so the word went in on it
         @(negedge clk);
      end
      s_valid = 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (pending != 0 || m_valid) begin
         @(negedge clk);
         waited++;
         if (waited > drain_timeout) abort_run("outputs did not drain, results are missing");
      end
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = error_count - errors_before;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("test %0d %s: %s, %0d outputs, %0d errors", tests_run, name,
               (errs == 0) ? "ok" : "failed", checked_count - checked_before, errs);
      errors_before  = error_count;
      checked_before = checked_count;
   endtask

   always @(negedge clk) begin
      logic bit_a;
      case (ready_mode)
         0: m_ready = 1'b1;
         1: begin
            m_ready    = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
         end
         default: begin
            bit_a      = ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
            m_ready    = bit_a & ready_lfsr[0];
            ready_lfsr = lfsr_step(ready_lfsr);
         end
      endcase
   end

   initial begin
      reset          = 1'b1;
      s_valid        = 1'b0;
      s_data         = '0;
      m_ready        = 1'b0;
      tests_run      = 0;
      tests_failed   = 0;
      errors_before  = 0;
      checked_before = 0;

      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);
      finish_test("reset");

      for (int i = 0; i < `DL_N_INPUTS; i++) vec[i] = '0;
      send_vector(0);
      wait_drained();
      finish_test("zero vector");

      repeat (6) begin
         random_vector();
         send_vector(0);
         wait_drained();
      end
      finish_test("single random vectors");

      ready_mode = 1;
      repeat (6) begin
         random_vector();
         send_vector(0);
         wait_drained();
      end
      finish_test("m_ready stalls");

      // vectors overlap with the draining outputs of the one before
      ready_mode = 2;
      repeat (8) begin
         random_vector();
         send_vector(3);
      end
      wait_drained();
      finish_test("back to back vectors");

      $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
               tests_run, tests_failed, checked_count, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock #(
   parameter realtime period = 4ns
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

// File: source/dense_layer_top.sv
`default_nettype none

`include "dense_layer_defs.svh"

module dense_layer_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    s_valid,
   input  dense_layer_pkg::word_t  s_data,
   output logic                    s_ready,
   output logic                    m_valid,
   input  logic                    m_ready,
   output dense_layer_pkg::word_t  m_data
);
   import dense_layer_pkg::*;

   logic        busy;
   logic        wr_en;
   in_addr_t    addr;
   mac_ctrl_t   mac_ctrl;
   word_t       x;
   lane_words_t weights;
   lane_words_t biases;
   lane_words_t results;

   layer_ctrl i_layer_ctrl (
      .clk      (clk),
      .reset    (reset),
      .s_valid  (s_valid),
      .s_ready  (s_ready),
      .busy     (busy),
      .addr     (addr),
      .wr_en    (wr_en),
      .mac_ctrl (mac_ctrl)
   );

   // the same address writes the vector in load and reads it back in compute
   input_buffer i_input_buffer (
      .clk     (clk),
      .wr_en   (wr_en),
      .addr    (addr),
      .wr_data (s_data),
      .rd_data (x)
   );

   weight_rom i_weight_rom (
      .clk     (clk),
      .addr    (addr),
      .weights (weights),
      .biases  (biases)
   );

   for (genvar j = 0; j < `DL_N_LANES; j++) begin : g_lane
      mac_lane #(
         .lane_index (j)
      ) i_mac_lane (
         .clk      (clk),
         .reset    (reset),
         .mac_ctrl (mac_ctrl),
         .x        (x),
         .weight   (weights[j]),
         .bias     (biases[j]),
         .result   (results[j])
      );
   end

   output_serializer i_output_serializer (
      .clk     (clk),
      .reset   (reset),
      .load    (mac_ctrl.capture),
      .results (results),
      .busy    (busy),
      .m_valid (m_valid),
      .m_ready (m_ready),
      .m_data  (m_data)
   );

endmodule

`default_nettype wire

// File: source/input_buffer.sv
`default_nettype none

`include "dense_layer_defs.svh"

module input_buffer (
   input  logic                      clk,
   input  logic                      wr_en,
   input  dense_layer_pkg::in_addr_t addr,
   input  dense_layer_pkg::word_t    wr_data,
   output dense_layer_pkg::word_t    rd_data
);
   import dense_layer_pkg::*;

   word_t mem [`DL_N_INPUTS];

   // read returns the old word when the same address is written
   always_ff @(posedge clk) begin
      rd_data <= mem[addr];
      if (wr_en) begin
         mem[addr] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// File: source/layer_ctrl.sv
`default_nettype none

`include "dense_layer_defs.svh"

module layer_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       s_valid,
   output logic                       s_ready,
   input  logic                       busy,
   output dense_layer_pkg::in_addr_t  addr,
   output logic                       wr_en,
   output dense_layer_pkg::mac_ctrl_t mac_ctrl
);
   import dense_layer_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;
   logic        last_addr;

   assign last_addr = (addr == in_addr_t'(`DL_N_INPUTS - 1));

   // input words are taken only in load
   // idle is the single wake-up cycle after reset
   assign s_ready = (state == load);
   assign wr_en   = s_valid && s_ready;

   always_comb begin
      next_state = state;
      case (state)
         idle: begin
            next_state = load;
         end
         load: begin
            if (wr_en && last_addr) begin
               next_state = compute;
            end
         end
         compute: begin
            if (last_addr) begin
               next_state = wait_out;
            end
         end
         wait_out: begin
            // hold the accumulators until the serializer has room
            if (!busy) begin
               next_state = load;
            end
         end
         default: begin
            next_state = idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   // one counter walks the buffer for writing and then for reading
   always_ff @(posedge clk) begin
      if (reset) begin
         addr <= '0;
      end else if (wr_en || state == compute) begin
         if (last_addr) begin
            addr <= '0;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   // strobes trail the address by the one cycle of memory read latency
   always_ff @(posedge clk) begin
      if (reset) begin
         mac_ctrl <= '0;
      end else begin
         mac_ctrl.clear   <= (state == compute) && (addr == '0);
         mac_ctrl.acc     <= (state == compute);
         mac_ctrl.capture <= (state == wait_out) && !busy;
      end
   end

   // the serializer must never be overwritten while it still has results
   a_capture_not_busy: assert property (
      @(posedge clk) disable iff (reset)
      !(mac_ctrl.capture && busy)
   );

   // a new vector must not overwrite words the lanes are still reading
   a_no_write_while_reading: assert property (
      @(posedge clk) disable iff (reset)
      wr_en |-> !mac_ctrl.acc
   );

endmodule

`default_nettype wire

// File: source/output_serializer.sv
`default_nettype none

`include "dense_layer_defs.svh"

module output_serializer (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         load,
   input  dense_layer_pkg::lane_words_t results,
   output logic                         busy,
   output logic                         m_valid,
   input  logic                         m_ready,
   output dense_layer_pkg::word_t       m_data
);
   import dense_layer_pkg::*;

   lane_words_t held;
   lane_sel_t   sel;
   logic        load_q;
   logic        last_lane;

   assign last_lane = (sel == lane_sel_t'(`DL_N_LANES - 1));
   assign m_data    = held[sel];

   // busy already covers the cycle in which the lane results settle
   assign busy = m_valid || load_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         load_q  <= 1'b0;
         m_valid <= 1'b0;
         sel     <= '0;
      end else begin
         load_q <= load;
         if (load_q) begin
            m_valid <= 1'b1;
            sel     <= '0;
         end else if (m_valid && m_ready) begin
            sel <= sel + 1'b1;
            if (last_lane) begin
               m_valid <= 1'b0;
            end
         end
      end
   end

   // lanes register on capture, so the copy is taken one cycle later
   always_ff @(posedge clk) begin
      if (load_q) begin
         held <= results;
      end
   end

   a_hold_when_stalled: assert property (
      @(posedge clk) disable iff (reset)
      m_valid && !m_ready |=> m_valid && $stable(m_data)
   );

endmodule

`default_nettype wire
